/* hw/bus_pkg.sv */
package bus_pkg;

  localparam int AXI_DATA_W = 64;
  localparam int LANE_W     = AXI_DATA_W / 2;  // one 32-bit half of a beat

  // AXI AxSIZE encodings
  typedef enum logic [2:0] {
    SIZE_BYTE = 3'b000,
    SIZE_HALF = 3'b001,
    SIZE_WORD = 3'b010
  } axi_size_t;

  typedef logic [AXI_DATA_W/8-1:0] strobe_t;

  // one data beat, whole or split by addr[2]
  typedef union packed {
    logic [AXI_DATA_W-1:0]       word;
    logic [1:0][LANE_W-1:0]      lane;
  } beat_u;

  // byte / half / word from the core strobe
  function automatic axi_size_t size_of_strobe(input strobe_t strb);
    case (strb)
      8'h01:   return SIZE_BYTE;
      8'h03:   return SIZE_HALF;
      8'h0f:   return SIZE_WORD;
      default: return SIZE_BYTE;
    endcase
  endfunction

endpackage

/* hw/mem_map_pkg.sv */
package mem_map_pkg;

  // core-local timer, answered inside the bus
  localparam logic [31:0] MTIME_LO_ADDR = 32'h0200_bff8;  // mtime[31:0]
  localparam logic [31:0] MTIME_HI_ADDR = 32'h0200_bffc;  // mtime[63:32]

endpackage

/* hw/clint_rd_if.sv */
`timescale 1ns/1ps

interface clint_rd_if #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
);

  logic [ADDR_W-1:0] addr;
  logic              req;    // single-cycle strobe
  logic [DATA_W-1:0] rdata;
  logic              rvalid;

  modport requester (output addr, output req, input rdata, input rvalid);

  modport responder (input addr, input req, output rdata, output rvalid);

endinterface

/* hw/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic clk,
  input  logic rst,
  clint_rd_if.responder clint
);
  import mem_map_pkg::*;

  logic [63:0] mtime;
  logic        sel_hi;

  assign sel_hi = (clint.addr == ADDR_W'(MTIME_HI_ADDR));

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime        <= '0;
      clint.rvalid <= 1'b0;
    end else begin
      mtime        <= mtime + 64'd1;  // free running
      clint.rvalid <= clint.req;
    end
  end

  // value sampled on the req edge
  always_ff @(posedge clk) begin
    if (clint.req) begin
      clint.rdata <= sel_hi ? DATA_W'(mtime[63:32]) : DATA_W'(mtime[31:0]);
    end
  end

endmodule

/* hw/bus_read_arbiter.sv */
`timescale 1ns/1ps

module bus_read_arbiter #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                clk,
  input  logic                rst,

  // ifu fetch
  input  logic [ADDR_W-1:0]   ifu_araddr_i,
  input  logic                ifu_arvalid_i,
  output logic [DATA_W-1:0]   ifu_rdata_o,
  output logic                ifu_rvalid_o,

  // lsu load
  input  logic [ADDR_W-1:0]   lsu_araddr_i,
  input  bus_pkg::strobe_t    lsu_rstrb_i,
  input  logic                lsu_arvalid_i,
  output logic [DATA_W-1:0]   lsu_rdata_o,
  output logic                lsu_rvalid_o,

  // axi read channels
  output logic [ADDR_W-1:0]   araddr_o,
  output bus_pkg::axi_size_t  arsize_o,
  output logic [7:0]          arlen_o,
  output logic [1:0]          arburst_o,
  output logic                arvalid_o,
  input  logic                arready_i,
  input  bus_pkg::beat_u      rdata_i,
  input  logic                rvalid_i,
  output logic                rready_o,

  clint_rd_if.requester       clint
);
  import bus_pkg::*;
  import mem_map_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_IFU_WAIT,
    ST_LSU_WAIT
  } state_t;

  state_t            state;
  logic              ar_pend;   // AR not yet accepted
  logic              timer_q;   // lsu read went to the timer
  logic [ADDR_W-1:0] araddr_q;
  axi_size_t         arsize_q;

  logic              is_timer;
  logic              ifu_grant;
  logic              lsu_grant;
  logic              lsu_done;
  logic [DATA_W-1:0] rd_lane;

  assign is_timer = (lsu_araddr_i == ADDR_W'(MTIME_LO_ADDR)) |
                    (lsu_araddr_i == ADDR_W'(MTIME_HI_ADDR));

  // ifu always wins in idle
  assign ifu_grant = (state == ST_IDLE) & ifu_arvalid_i;
  assign lsu_grant = (state == ST_IDLE) & ~ifu_arvalid_i & lsu_arvalid_i;

  assign lsu_done  = timer_q ? clint.rvalid : rvalid_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      ar_pend <= 1'b0;
      timer_q <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (ifu_grant) begin
            state   <= ST_IFU_WAIT;
            ar_pend <= 1'b1;
            timer_q <= 1'b0;
          end else if (lsu_grant) begin
            state   <= ST_LSU_WAIT;
            ar_pend <= ~is_timer;  // timer reads skip AR
            timer_q <= is_timer;
          end
        end
        ST_IFU_WAIT: begin
          if (ar_pend & arready_i) ar_pend <= 1'b0;
          if (rvalid_i) state <= ST_IDLE;
        end
        ST_LSU_WAIT: begin
          if (ar_pend & arready_i) ar_pend <= 1'b0;
          if (lsu_done) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // request payload, held while arvalid is up
  always_ff @(posedge clk) begin
    if (ifu_grant) begin
      araddr_q <= ifu_araddr_i;
      arsize_q <= SIZE_WORD;
    end else if (lsu_grant) begin
      araddr_q <= lsu_araddr_i;
      arsize_q <= size_of_strobe(lsu_rstrb_i);
    end
  end

  assign araddr_o  = araddr_q;
  assign arsize_o  = arsize_q;
  assign arlen_o   = 8'd0;     // single beat
  assign arburst_o = 2'b01;
  assign arvalid_o = ar_pend;
  assign rready_o  = 1'b1;

  assign clint.addr = lsu_araddr_i;
  assign clint.req  = lsu_grant & is_timer;

  // pick 32-bit half of the beat
  assign rd_lane = DATA_W'(rdata_i.lane[araddr_q[2]]);

  assign ifu_rdata_o  = rd_lane;
  assign ifu_rvalid_o = (state == ST_IFU_WAIT) & rvalid_i;
  assign lsu_rdata_o  = timer_q ? clint.rdata : rd_lane;
  assign lsu_rvalid_o = (state == ST_LSU_WAIT) & lsu_done;

endmodule

/* hw/bus_store_path.sv */
`timescale 1ns/1ps

module bus_store_path #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                clk,
  input  logic                rst,

  // lsu store
  input  logic [ADDR_W-1:0]   lsu_awaddr_i,
  input  logic [DATA_W-1:0]   lsu_wdata_i,
  input  bus_pkg::strobe_t    lsu_wstrb_i,
  input  logic                lsu_wvalid_i,
  output logic                lsu_wready_o,

  // axi write channels
  output logic [ADDR_W-1:0]   awaddr_o,
  output bus_pkg::axi_size_t  awsize_o,
  output logic                awvalid_o,
  input  logic                awready_i,
  output bus_pkg::beat_u      wdata_o,
  output bus_pkg::strobe_t    wstrb_o,
  output logic                wlast_o,
  output logic                wvalid_o,
  input  logic                wready_i,
  input  logic                bvalid_i,
  output logic                bready_o
);
  import bus_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_DONE
  } state_t;

  state_t            state;
  logic              aw_done;
  logic              w_done;
  logic              active;
  logic              aw_hs;
  logic              w_hs;
  logic [DATA_W-1:0] wdata_sh;
  logic [3:0]        strb_sh;

  assign active = ((state == ST_IDLE) & lsu_wvalid_i) | (state == ST_ISSUE);

  assign awvalid_o = active & ~aw_done;
  assign wvalid_o  = active & ~w_done;
  assign aw_hs     = awvalid_o & awready_i;
  assign w_hs      = wvalid_o & wready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          aw_done <= aw_hs;
          w_done  <= w_hs;
          if (lsu_wvalid_i) state <= ST_ISSUE;
        end
        ST_ISSUE: begin
          if (aw_hs) aw_done <= 1'b1;
          if (w_hs) w_done <= 1'b1;
          if (bvalid_i) state <= ST_DONE;  // response ends the store
        end
        ST_DONE: state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // byte lane placement inside the 32-bit word
  assign wdata_sh = lsu_wdata_i << {lsu_awaddr_i[1:0], 3'b000};
  assign strb_sh  = lsu_wstrb_i[3:0] << lsu_awaddr_i[1:0];

  assign wdata_o.lane[0] = LANE_W'(wdata_sh);
  assign wdata_o.lane[1] = LANE_W'(wdata_sh);
  assign wstrb_o = lsu_awaddr_i[2] ? {strb_sh, 4'b0000} : {4'b0000, strb_sh};

  assign awaddr_o     = lsu_awaddr_i;
  assign awsize_o     = size_of_strobe(lsu_wstrb_i);
  assign wlast_o      = wvalid_o;  // single beat
  assign bready_o     = 1'b1;
  assign lsu_wready_o = (state == ST_ISSUE) & bvalid_i;

endmodule

/* hw/core_bus_top.sv */
`timescale 1ns/1ps

module core_bus_top #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                            clk,
  input  logic                            rst,

  // ifu
  input  logic [ADDR_W-1:0]               ifu_araddr_i,
  input  logic                            ifu_arvalid_i,
  output logic [DATA_W-1:0]               ifu_rdata_o,
  output logic                            ifu_rvalid_o,

  // lsu load
  input  logic [ADDR_W-1:0]               lsu_araddr_i,
  input  logic [7:0]                      lsu_rstrb_i,
  input  logic                            lsu_arvalid_i,
  output logic [DATA_W-1:0]               lsu_rdata_o,
  output logic                            lsu_rvalid_o,

  // lsu store
  input  logic [ADDR_W-1:0]               lsu_awaddr_i,
  input  logic [DATA_W-1:0]               lsu_wdata_i,
  input  logic [7:0]                      lsu_wstrb_i,
  input  logic                            lsu_wvalid_i,
  output logic                            lsu_wready_o,

  // axi4 master
  output logic [ADDR_W-1:0]               araddr_o,
  output logic [2:0]                      arsize_o,
  output logic [7:0]                      arlen_o,
  output logic [1:0]                      arburst_o,
  output logic                            arvalid_o,
  input  logic                            arready_i,
  input  logic [bus_pkg::AXI_DATA_W-1:0]  rdata_i,
  input  logic                            rvalid_i,
  output logic                            rready_o,
  output logic [ADDR_W-1:0]               awaddr_o,
  output logic [2:0]                      awsize_o,
  output logic                            awvalid_o,
  input  logic                            awready_i,
  output logic [bus_pkg::AXI_DATA_W-1:0]  wdata_o,
  output logic [7:0]                      wstrb_o,
  output logic                            wlast_o,
  output logic                            wvalid_o,
  input  logic                            wready_i,
  input  logic                            bvalid_i,
  output logic                            bready_o
);

  clint_rd_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) clint_bus ();

  bus_read_arbiter #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_rd_arb (
    .clk           (clk),
    .rst           (rst),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_rdata_o   (ifu_rdata_o),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_rstrb_i   (lsu_rstrb_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .araddr_o      (araddr_o),
    .arsize_o      (arsize_o),
    .arlen_o       (arlen_o),
    .arburst_o     (arburst_o),
    .arvalid_o     (arvalid_o),
    .arready_i     (arready_i),
    .rdata_i       (rdata_i),
    .rvalid_i      (rvalid_i),
    .rready_o      (rready_o),
    .clint         (clint_bus)
  );

  bus_store_path #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_st_path (
    .clk          (clk),
    .rst          (rst),
    .lsu_awaddr_i (lsu_awaddr_i),
    .lsu_wdata_i  (lsu_wdata_i),
    .lsu_wstrb_i  (lsu_wstrb_i),
    .lsu_wvalid_i (lsu_wvalid_i),
    .lsu_wready_o (lsu_wready_o),
    .awaddr_o     (awaddr_o),
    .awsize_o     (awsize_o),
    .awvalid_o    (awvalid_o),
    .awready_i    (awready_i),
    .wdata_o      (wdata_o),
    .wstrb_o      (wstrb_o),
    .wlast_o      (wlast_o),
    .wvalid_o     (wvalid_o),
    .wready_i     (wready_i),
    .bvalid_i     (bvalid_i),
    .bready_o     (bready_o)
  );

  clint_timer #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_timer (
    .clk   (clk),
    .rst   (rst),
    .clint (clint_bus)
  );

endmodule

/* test/tb_core_bus.sv */
`timescale 1ns/1ps

module tb_core_bus;
  import bus_pkg::*;
  import mem_map_pkg::*;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int N_OPS  = 200;
  localparam logic [31:0] BASE = 32'h8000_0000;

  logic clk = 1'b0;
  logic rst;
  logic [ADDR_W-1:0] ifu_araddr_i, lsu_araddr_i, lsu_awaddr_i, araddr_o, awaddr_o;
  logic ifu_arvalid_i, ifu_rvalid_o, lsu_arvalid_i, lsu_rvalid_o, lsu_wvalid_i, lsu_wready_o;
  logic [DATA_W-1:0] ifu_rdata_o, lsu_rdata_o, lsu_wdata_i;
  logic [7:0] lsu_rstrb_i, lsu_wstrb_i, wstrb_o, arlen_o;
  logic [2:0] arsize_o, awsize_o;
  logic [1:0] arburst_o;
  logic arvalid_o, arready_i, rvalid_i, rready_o, awvalid_o, awready_i;
  logic wlast_o, wvalid_o, wready_i, bvalid_i, bready_o;
  logic [63:0] rdata_i, wdata_o;

  logic [7:0]  ref_mem [128];  // byte model of the slave window
  logic [63:0] slv_mem [16];
  logic [63:0] tcount;         // mtime model
  logic [31:0] mseed = 32'd79;
  logic [31:0] sseed = 32'd79 * 32'd3;

  // monitor results
  logic ar_fire, aw_fire, w_fire, ar_wait, aw_wait, w_wait;
  logic [31:0] ar_addr_q, ar_hold, aw_hold, first_araddr;
  axi_size_t ar_size_q;
  int ar_count;
  logic [31:0] exp_waddr, exp_wlane;
  strobe_t exp_wstrb;
  axi_size_t exp_wsize;

  // slave state
  logic [1:0] ar_dly, aw_dly, w_dly, r_dly, b_dly;
  logic r_pend, b_pend, aw_got, w_got;
  logic [31:0] r_addr, st_addr;
  logic [63:0] st_data;
  strobe_t st_strb;

  core_bus_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) uut (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    if (rst) tcount <= 64'd0;
    else tcount <= tcount + 64'd1;
  end

  function automatic logic [31:0] next_rand(inout logic [31:0] s);
    s = s * 32'd1664525 + 32'd1013904223;
    return s;
  endfunction

  function automatic logic [31:0] ref_word(input logic [31:0] a);
    logic [6:0] b;
    b = {a[6:2], 2'b00};
    return {ref_mem[b + 7'd3], ref_mem[b + 7'd2], ref_mem[b + 7'd1], ref_mem[b]};
  endfunction

  function automatic axi_size_t expect_size(input strobe_t s);
    if (s == 8'h0f) return SIZE_WORD;
    if (s == 8'h03) return SIZE_HALF;
    return SIZE_BYTE;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_rdata(input logic [DATA_W-1:0] got, exp, input string what);
    if (got !== exp)
      fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_strobe(input strobe_t got, exp, input string what);
    if (got !== exp)
      fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_size(input axi_size_t got, exp, input string what);
    if (got !== exp)
      fail_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp));
  endtask

  task automatic check_addr(input logic [ADDR_W-1:0] got, exp, input string what);
    if (got !== exp)
      fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_ctrl(input logic [7:0] got, exp, input string what);
    if (got !== exp)
      fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  // handshakes seen at the rising edge
  always @(posedge clk) begin
    beat_u wb;
    ar_fire = arvalid_o & arready_i;
    aw_fire = awvalid_o & awready_i;
    w_fire  = wvalid_o & wready_i;
    if (ar_wait) begin
      if (!arvalid_o) fail_run("arvalid dropped before its handshake");
      check_addr(araddr_o, ar_hold, "held araddr");
    end
    if (aw_wait) begin
      if (!awvalid_o) fail_run("awvalid dropped before its handshake");
      check_addr(awaddr_o, aw_hold, "held awaddr");
    end
    if (w_wait && !wvalid_o) fail_run("wvalid dropped before its handshake");
    if (ar_fire) begin
      ar_addr_q = araddr_o;
      ar_size_q = axi_size_t'(arsize_o);
      check_ctrl(arlen_o, 8'd0, "arlen");
      check_ctrl({6'd0, arburst_o}, 8'd1, "arburst");  // incr
      if (ar_count == 0) first_araddr = araddr_o;
      ar_count++;
    end
    if (rvalid_i) check_ctrl({7'd0, rready_o}, 8'd1, "rready");
    if (bvalid_i) check_ctrl({7'd0, bready_o}, 8'd1, "bready");
    if (aw_fire) begin
      check_addr(awaddr_o, exp_waddr, "awaddr");
      check_size(axi_size_t'(awsize_o), exp_wsize, "awsize");
    end
    if (w_fire) begin
      wb = wdata_o;
      check_strobe(wstrb_o, exp_wstrb, "wstrb");
      check_rdata(wb.lane[0], exp_wlane, "wdata low lane");
      check_rdata(wb.lane[1], exp_wlane, "wdata high lane");
      if (!wlast_o) fail_run("wlast low on the only write beat");
    end
    ar_wait = arvalid_o & ~arready_i;
    aw_wait = awvalid_o & ~awready_i;
    w_wait  = wvalid_o & ~wready_i;
    ar_hold = araddr_o;
    aw_hold = awaddr_o;
  end

  // axi slave, ready either kept up or raised 1..4 cycles into a wait
  always @(negedge clk) begin
    logic [31:0] r;
    r = next_rand(sseed);
    rvalid_i = 1'b0;
    bvalid_i = 1'b0;
    if (ar_fire) begin
      arready_i = r[16];
      ar_dly = r[18:17];
      r_dly = r[20:19];
      r_pend = 1'b1;
      r_addr = ar_addr_q;
    end else if (ar_wait) begin
      if (ar_dly == 2'd0) arready_i = 1'b1;
      else ar_dly--;
    end
    if (aw_fire) begin
      awready_i = r[21];
      aw_dly = r[23:22];
      aw_got = 1'b1;
      st_addr = awaddr_o;
    end else if (aw_wait) begin
      if (aw_dly == 2'd0) awready_i = 1'b1;
      else aw_dly--;
    end
    if (w_fire) begin
      wready_i = r[24];
      w_dly = r[26:25];
      w_got = 1'b1;
      st_data = wdata_o;
      st_strb = wstrb_o;
    end else if (w_wait) begin
      if (w_dly == 2'd0) wready_i = 1'b1;
      else w_dly--;
    end
    if (aw_got && w_got) begin  // merge under strobe
      for (int k = 0; k < 8; k++)
        if (st_strb[k]) slv_mem[st_addr[6:3]][8*k +: 8] = st_data[8*k +: 8];
      aw_got = 1'b0;
      w_got = 1'b0;
      b_pend = 1'b1;
      b_dly = r[28:27];
    end
    if (r_pend) begin
      if (r_dly == 2'd0) begin
        rvalid_i = 1'b1;
        rdata_i = slv_mem[r_addr[6:3]];
        r_pend = 1'b0;
      end else r_dly--;
    end
    if (b_pend) begin
      if (b_dly == 2'd0) begin
        bvalid_i = 1'b1;
        b_pend = 1'b0;
      end else b_dly--;
    end
  end

  task automatic fetch_word(input logic [31:0] a);
    @(negedge clk);
    ifu_araddr_i = a;
    ifu_arvalid_i = 1'b1;
    do @(posedge clk); while (!ifu_rvalid_o);
    check_rdata(ifu_rdata_o, ref_word(a), "ifu rdata");
    check_size(ar_size_q, SIZE_WORD, "ifu arsize");
    check_addr(ar_addr_q, a, "ifu araddr");
    @(negedge clk);
    ifu_arvalid_i = 1'b0;
  endtask

  task automatic load_word(input logic [31:0] a, input strobe_t s);
    @(negedge clk);
    lsu_araddr_i = a;
    lsu_rstrb_i = s;
    lsu_arvalid_i = 1'b1;
    do @(posedge clk); while (!lsu_rvalid_o);
    check_rdata(lsu_rdata_o, ref_word(a), "lsu rdata");
    check_size(ar_size_q, expect_size(s), "lsu arsize");
    check_addr(ar_addr_q, a, "lsu araddr");
    @(negedge clk);
    lsu_arvalid_i = 1'b0;
  endtask

  task automatic store_word(input logic [31:0] a, input strobe_t s, input logic [31:0] d);
    int off;
    off = int'(a[1:0]);
    exp_waddr = a;
    exp_wsize = expect_size(s);
    exp_wstrb = '0;
    exp_wlane = '0;
    // byte k of the store moves to byte k + off, bytes past the word are lost
    for (int k = 0; k + off < 4; k++) begin
      exp_wlane[8*(k+off) +: 8] = d[8*k +: 8];
      if (s[k]) begin
        exp_wstrb[(a[2] ? 4 : 0) + k + off] = 1'b1;
        ref_mem[{a[6:2], 2'b00} + 7'(k + off)] = d[8*k +: 8];
      end
    end
    @(negedge clk);
    lsu_awaddr_i = a;
    lsu_wdata_i = d;
    lsu_wstrb_i = s;
    lsu_wvalid_i = 1'b1;
    do @(posedge clk); while (!lsu_wready_o);
    @(negedge clk);
    lsu_wvalid_i = 1'b0;
    repeat (2) begin
      @(posedge clk);
      if (lsu_wready_o) fail_run("second lsu_wready pulse for one store");
    end
    load_word(a, 8'h0f);  // read back the merged word
  endtask

  task automatic fetch_and_load(input logic [31:0] ai, input logic [31:0] al);
    logic got_i;
    logic got_l;
    got_i = 1'b0;
    got_l = 1'b0;
    @(negedge clk);
    ar_count = 0;
    ifu_araddr_i = ai;
    ifu_arvalid_i = 1'b1;
    lsu_araddr_i = al;
    lsu_rstrb_i = 8'h0f;
    lsu_arvalid_i = 1'b1;
    while (!(got_i && got_l)) begin
      @(posedge clk);
      if (lsu_rvalid_o) begin
        if (!got_i) fail_run("LSU load served before the IFU fetch");
        check_rdata(lsu_rdata_o, ref_word(al), "lsu rdata after ifu");
        got_l = 1'b1;
      end
      if (ifu_rvalid_o) begin
        check_rdata(ifu_rdata_o, ref_word(ai), "ifu rdata with lsu pending");
        got_i = 1'b1;
      end
      @(negedge clk);
      if (got_i) ifu_arvalid_i = 1'b0;
      if (got_l) lsu_arvalid_i = 1'b0;
    end
    check_addr(first_araddr, ai, "first araddr");
  endtask

  task automatic read_mtime(input logic hi);
    logic [31:0] a;
    logic [31:0] exp;
    a = hi ? MTIME_HI_ADDR : MTIME_LO_ADDR;
    @(negedge clk);
    lsu_araddr_i = a;
    lsu_rstrb_i = 8'h0f;
    lsu_arvalid_i = 1'b1;
    @(posedge clk);
    exp = hi ? tcount[63:32] : tcount[31:0];
    if (arvalid_o) fail_run("timer load raised arvalid");
    @(posedge clk);
    if (!lsu_rvalid_o) fail_run("timer reply not one cycle after the request");
    check_rdata(lsu_rdata_o, exp, "mtime");
    if (arvalid_o) fail_run("timer load raised arvalid");
    @(negedge clk);
    lsu_arvalid_i = 1'b0;
  endtask

  initial begin
    #(N_OPS * 40 * 4 + 100);
    fail_run("timeout: the tests did not finish in time");
  end

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    strobe_t s;
    rst = 1'b1;
    {ifu_araddr_i, ifu_arvalid_i, lsu_araddr_i, lsu_rstrb_i, lsu_arvalid_i} = '0;
    {lsu_awaddr_i, lsu_wdata_i, lsu_wstrb_i, lsu_wvalid_i} = '0;
    {arready_i, rdata_i, rvalid_i, awready_i, wready_i, bvalid_i} = '0;
    {ar_fire, aw_fire, w_fire, ar_wait, aw_wait, w_wait} = '0;
    {ar_dly, aw_dly, w_dly, r_pend, b_pend, aw_got, w_got} = '0;
    for (int i = 0; i < 128; i++) begin
      ref_mem[i] = 8'(i * 37) ^ 8'h5a;  // distinct per byte address
      slv_mem[i / 8][8*(i % 8) +: 8] = 8'(i * 37) ^ 8'h5a;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < N_OPS; n++) begin
      r = next_rand(mseed);
      a = BASE | {25'd0, r[22:16]};
      b = BASE | {25'd0, r[29:23]};
      case (r[2:0])
        3'd0: s = 8'h01;
        3'd1, 3'd2: s = 8'h03;
        default: s = 8'h0f;
      endcase
      case (r[6:4])
        3'd0: fetch_word({a[31:2], 2'b00});
        3'd1, 3'd2: load_word(a, s);
        3'd3, 3'd4: store_word(a, s, next_rand(mseed));
        3'd5: fetch_and_load({a[31:2], 2'b00}, b);
        default: read_mtime(r[8]);
      endcase
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* vlog.f */
hw/bus_pkg.sv
hw/mem_map_pkg.sv
hw/clint_rd_if.sv
hw/clint_timer.sv
hw/bus_read_arbiter.sv
hw/bus_store_path.sv
hw/core_bus_top.sv
test/tb_core_bus.sv

/* Makefile */
SIM := obj_dir/Vtb_core_bus

.PHONY: all run clean

all: run

$(SIM): vlog.f $(wildcard hw/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --top-module tb_core_bus -f vlog.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
